//--- l2cache.f
l2cache_geom_pkg.sv
l2cache_ctrl_pkg.sv
l2cache_array.sv
l2cache_datapath.sv
l2cache_control.sv
l2cache.sv
tb_l2cache.sv

//--- Bender.yml
package:
  name: l2cache

sources:
  - l2cache_geom_pkg.sv
  - l2cache_ctrl_pkg.sv
  - l2cache_array.sv
  - l2cache_datapath.sv
  - l2cache_control.sv
  - l2cache.sv
  - target: test
    files:
      - tb_l2cache.sv

//--- tb_l2cache.sv
`timescale 1ns/1ps

module tb_l2cache;

    localparam int num_rows = 12;
    // memory model covers addresses below 0x8000
    localparam int model_lines = 1024;

    logic                       clk;
    logic                       rst_n;
    logic                       mem_read;
    logic                       mem_write;
    l2cache_geom_pkg::l2_addr_t mem_address;
    l2cache_geom_pkg::l2_line_t mem_wdata;
    l2cache_geom_pkg::l2_line_t mem_rdata;
    logic                       mem_resp;
    logic                       pmem_read;
    logic                       pmem_write;
    l2cache_geom_pkg::l2_addr_t pmem_address;
    l2cache_geom_pkg::l2_line_t pmem_wdata;
    l2cache_geom_pkg::l2_line_t pmem_rdata;
    logic                       pmem_resp;

    integer seed = 32'hebde;

    // memory model state and traffic seen during one row
    l2cache_geom_pkg::l2_line_t mem_model [model_lines];
    int                         read_count;
    int                         write_count;
    int                         writes_at_fetch;
    l2cache_geom_pkg::l2_addr_t wb_addr_seen;
    l2cache_geom_pkg::l2_line_t wb_line_seen;

    // stimulus table
    string                      row_name      [num_rows];
    bit                         row_write     [num_rows];
    l2cache_geom_pkg::l2_addr_t row_addr      [num_rows];
    l2cache_geom_pkg::l2_line_t row_wdata     [num_rows];
    l2cache_geom_pkg::l2_line_t row_rdata     [num_rows];
    int                         row_reads     [num_rows];
    int                         row_writes    [num_rows];
    l2cache_geom_pkg::l2_addr_t row_wb_addr   [num_rows];
    l2cache_geom_pkg::l2_line_t row_wb_line   [num_rows];

    l2cache u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .mem_address  (mem_address),
        .mem_wdata    (mem_wdata),
        .mem_rdata    (mem_rdata),
        .mem_resp     (mem_resp),
        .pmem_read    (pmem_read),
        .pmem_write   (pmem_write),
        .pmem_address (pmem_address),
        .pmem_wdata   (pmem_wdata),
        .pmem_rdata   (pmem_rdata),
        .pmem_resp    (pmem_resp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // initial memory contents hold the line address eight times
    function automatic l2cache_geom_pkg::l2_line_t pattern_line(
        input l2cache_geom_pkg::l2_addr_t line_addr
    );
        return {8{line_addr}};
    endfunction

    // line compare
    task automatic check_line(input string name, input l2cache_geom_pkg::l2_line_t expected,
                              input l2cache_geom_pkg::l2_line_t actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            $display("test failed");
            $fatal(1, "line mismatch");
        end
    endtask

    // address compare
    task automatic check_addr(input string name, input l2cache_geom_pkg::l2_addr_t expected,
                              input l2cache_geom_pkg::l2_addr_t actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            $display("test failed");
            $fatal(1, "address mismatch");
        end
    endtask

    // transfer and cycle counts
    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("CHECK FAILED %s expected %0d actual %0d", name, expected, actual);
            $display("test failed");
            $fatal(1, "count mismatch");
        end
    endtask

    task automatic add_row(input int i, input string name, input bit wr,
                           input l2cache_geom_pkg::l2_addr_t addr,
                           input l2cache_geom_pkg::l2_line_t wdata,
                           input l2cache_geom_pkg::l2_line_t rdata,
                           input int reads, input int writes,
                           input l2cache_geom_pkg::l2_addr_t wb_addr,
                           input l2cache_geom_pkg::l2_line_t wb_line);
        row_name[i]    = name;
        row_write[i]   = wr;
        row_addr[i]    = addr;
        row_wdata[i]   = wdata;
        row_rdata[i]   = rdata;
        row_reads[i]   = reads;
        row_writes[i]  = writes;
        row_wb_addr[i] = wb_addr;
        row_wb_line[i] = wb_line;
    endtask

    task automatic build_table();
        l2cache_geom_pkg::l2_line_t wa;
        l2cache_geom_pkg::l2_line_t wc;
        wa = {4{64'h0123_4567_89ab_1060}};
        wc = {4{64'hfedc_ba98_7654_3060}};
        // set 3 holds tags 0x1060, 0x2060 and 0x3060
        // lru starts at way 0
        add_row(0, "cold_read_a", 0, 32'h1060, '0, pattern_line(32'h1060), 1, 0, '0, '0);
        add_row(1, "repeat_read_a", 0, 32'h1064, '0, pattern_line(32'h1060), 0, 0, '0, '0);
        add_row(2, "write_hit_a", 1, 32'h1060, wa, '0, 0, 0, '0, '0);
        add_row(3, "read_after_write_a", 0, 32'h1060, '0, wa, 0, 0, '0, '0);
        add_row(4, "cold_read_b", 0, 32'h2060, '0, pattern_line(32'h2060), 1, 0, '0, '0);
        // a is lru and dirty
        add_row(5, "evict_dirty_a", 0, 32'h3060, '0, pattern_line(32'h3060), 1, 1,
                32'h1060, wa);
        // b is lru and clean
        // a comes back from memory with its written data
        add_row(6, "evict_clean_b", 0, 32'h1060, '0, wa, 1, 0, '0, '0);
        add_row(7, "write_hit_c", 1, 32'h3060, wc, '0, 0, 0, '0, '0);
        add_row(8, "evict_clean_a", 0, 32'h2060, '0, pattern_line(32'h2060), 1, 0, '0, '0);
        add_row(9, "evict_dirty_c", 0, 32'h1060, '0, wa, 1, 1, 32'h3060, wc);
        add_row(10, "reread_c", 0, 32'h307f, '0, wc, 1, 0, '0, '0);
        // different set untouched by the rows above
        add_row(11, "other_set_read", 0, 32'h5080, '0, pattern_line(32'h5080), 1, 0, '0, '0);
    endtask

    // memory model answers after 1 to 6 cycles
    initial begin : memory_model
        int unsigned delay;
        int          line;
        for (int i = 0; i < model_lines; i++) begin
            mem_model[i] = pattern_line(l2cache_geom_pkg::l2_addr_t'(i) << 5);
        end
        pmem_resp  = 1'b0;
        pmem_rdata = '0;
        forever begin
            @(negedge clk);
            pmem_resp = 1'b0;
            if (rst_n && (pmem_read || pmem_write)) begin
                delay = 1 + ({$random(seed)} % 6);
                repeat (delay - 1) @(negedge clk);
                // whole lines only, inside the modeled range
                if (pmem_address[31:15] != '0 || pmem_address[4:0] != '0) begin
                    $display("memory access at %h is not a line address in the modeled range",
                             pmem_address);
                    $display("test failed");
                    $fatal(1, "bad memory address");
                end
                line = pmem_address[14:5];
                if (pmem_write) begin
                    mem_model[line] = pmem_wdata;
                    wb_addr_seen    = pmem_address;
                    wb_line_seen    = pmem_wdata;
                    write_count++;
                end else begin
                    pmem_rdata      = mem_model[line];
                    writes_at_fetch = write_count;
                    read_count++;
                end
                pmem_resp = 1'b1;
            end
        end
    end

    // one request then its response and the memory traffic it caused
    task automatic run_row(input int i);
        int                         resp_count;
        int                         latency;
        l2cache_geom_pkg::l2_line_t got;
        read_count      = 0;
        write_count     = 0;
        writes_at_fetch = 0;
        mem_read        = !row_write[i];
        mem_write       = row_write[i];
        mem_address     = row_addr[i];
        mem_wdata       = row_wdata[i];
        @(negedge clk);
        latency = 1;
        while (!mem_resp) begin
            @(negedge clk);
            latency++;
        end
        resp_count = 1;
        got        = mem_rdata;
        @(negedge clk);
        resp_count += int'(mem_resp);
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        @(negedge clk);
        resp_count += int'(mem_resp);
        // read data only matters for reads
        if (!row_write[i]) begin
            check_line({row_name[i], "_rdata"}, row_rdata[i], got);
        end
        check_count({row_name[i], "_resp"}, 1, resp_count);
        check_count({row_name[i], "_pmem_reads"}, row_reads[i], read_count);
        check_count({row_name[i], "_pmem_writes"}, row_writes[i], write_count);
        if (row_writes[i] > 0) begin
            check_addr({row_name[i], "_wb_addr"}, row_wb_addr[i], wb_addr_seen);
            check_line({row_name[i], "_wb_line"}, row_wb_line[i], wb_line_seen);
        end
        // write-back has to land before the fetch
        if (row_reads[i] > 0) begin
            check_count({row_name[i], "_wb_order"}, row_writes[i], writes_at_fetch);
        end
        // a hit answers one cycle after acceptance
        if (row_reads[i] == 0 && row_writes[i] == 0) begin
            check_count({row_name[i], "_hit_latency"}, 1, latency);
        end
    endtask

    // worst case per row is well under 40 cycles
    initial begin : watchdog
        repeat (num_rows * 40 + 8) @(posedge clk);
        $display("timeout, the cache stopped answering in state %s",
                 u_dut.u_control.state.name());
        $display("test failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rst_n       = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        mem_address = '0;
        mem_wdata   = '0;
        build_table();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        // nothing pending out of reset
        check_count("reset_quiet", 0, int'(mem_resp) + int'(pmem_read) + int'(pmem_write));
        for (int i = 0; i < num_rows; i++) begin
            run_row(i);
        end
        $display("test passed");
        $finish;
    end

endmodule

//--- l2cache.sv
`timescale 1ns/1ps

module l2cache (
    input  logic                       clk,
    input  logic                       rst_n,
    // requester
    input  logic                       mem_read,
    input  logic                       mem_write,
    input  l2cache_geom_pkg::l2_addr_t mem_address,
    input  l2cache_geom_pkg::l2_line_t mem_wdata,
    output l2cache_geom_pkg::l2_line_t mem_rdata,
    output logic                       mem_resp,
    // physical memory
    output logic                       pmem_read,
    output logic                       pmem_write,
    output l2cache_geom_pkg::l2_addr_t pmem_address,
    output l2cache_geom_pkg::l2_line_t pmem_wdata,
    input  l2cache_geom_pkg::l2_line_t pmem_rdata,
    input  logic                       pmem_resp
);

    // control to datapath
    l2cache_ctrl_pkg::way_src_t  way_src;
    l2cache_ctrl_pkg::addr_src_t addr_src;
    logic                        load_line;
    logic                        load_valid;
    logic                        load_dirty;
    logic                        load_lru;
    logic                        load_wb_line;
    logic                        line_from_mem;
    logic                        valid_in;
    logic                        dirty_in;

    // datapath to control
    logic                        hit;
    logic                        victim_dirty;

    // sequencing
    l2cache_control u_control (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .mem_resp     (mem_resp),
        .pmem_resp    (pmem_resp),
        .pmem_read    (pmem_read),
        .pmem_write   (pmem_write),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .way_src      (way_src),
        .addr_src     (addr_src),
        .load_line    (load_line),
        .load_valid   (load_valid),
        .load_dirty   (load_dirty),
        .load_lru     (load_lru),
        .load_wb_line (load_wb_line),
        .line_from_mem(line_from_mem),
        .valid_in     (valid_in),
        .dirty_in     (dirty_in)
    );

    // arrays, compare and muxing
    l2cache_datapath u_datapath (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_address  (mem_address),
        .mem_wdata    (mem_wdata),
        .mem_rdata    (mem_rdata),
        .pmem_address (pmem_address),
        .pmem_wdata   (pmem_wdata),
        .pmem_rdata   (pmem_rdata),
        .way_src      (way_src),
        .addr_src     (addr_src),
        .load_line    (load_line),
        .load_valid   (load_valid),
        .load_dirty   (load_dirty),
        .load_lru     (load_lru),
        .load_wb_line (load_wb_line),
        .line_from_mem(line_from_mem),
        .valid_in     (valid_in),
        .dirty_in     (dirty_in),
        .hit          (hit),
        .victim_dirty (victim_dirty)
    );

endmodule

//--- l2cache_control.sv
`timescale 1ns/1ps

module l2cache_control (
    input  logic                        clk,
    input  logic                        rst_n,
    // requester handshake
    input  logic                        mem_read,
    input  logic                        mem_write,
    output logic                        mem_resp,
    // memory handshake
    input  logic                        pmem_resp,
    output logic                        pmem_read,
    output logic                        pmem_write,
    // datapath status
    input  logic                        hit,
    input  logic                        victim_dirty,
    // datapath controls
    output l2cache_ctrl_pkg::way_src_t  way_src,
    output l2cache_ctrl_pkg::addr_src_t addr_src,
    output logic                        load_line,
    output logic                        load_valid,
    output logic                        load_dirty,
    output logic                        load_lru,
    output logic                        load_wb_line,
    output logic                        line_from_mem,
    output logic                        valid_in,
    output logic                        dirty_in
);

    l2cache_ctrl_pkg::l2_state_t state;
    l2cache_ctrl_pkg::l2_state_t state_next;

    // state register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= l2cache_ctrl_pkg::idle;
        end else begin
            state <= state_next;
        end
    end

    // next state and outputs
    always_comb begin
        // defaults, everything quiet
        state_next    = state;
        mem_resp      = 1'b0;
        pmem_read     = 1'b0;
        pmem_write    = 1'b0;
        way_src       = l2cache_ctrl_pkg::way_hit;
        addr_src      = l2cache_ctrl_pkg::addr_req;
        load_line     = 1'b0;
        load_valid    = 1'b0;
        load_dirty    = 1'b0;
        load_lru      = 1'b0;
        load_wb_line  = 1'b0;
        line_from_mem = 1'b0;
        valid_in      = 1'b0;
        dirty_in      = 1'b0;

        unique case (state)
            l2cache_ctrl_pkg::idle: begin
                // take a request on this edge
                if (mem_read || mem_write) begin
                    state_next = l2cache_ctrl_pkg::hit_check;
                end
            end

            l2cache_ctrl_pkg::hit_check: begin
                if (hit) begin
                    // answer now, touch lru
                    mem_resp   = 1'b1;
                    load_lru   = 1'b1;
                    state_next = l2cache_ctrl_pkg::idle;
                    if (mem_write) begin
                        // write hit replaces the line and marks it dirty
                        load_line  = 1'b1;
                        load_dirty = 1'b1;
                        dirty_in   = 1'b1;
                    end
                end else begin
                    way_src = l2cache_ctrl_pkg::way_lru;
                    if (victim_dirty) begin
                        // snapshot victim before it is overwritten
                        load_wb_line = 1'b1;
                        state_next   = l2cache_ctrl_pkg::write_back;
                    end else begin
                        state_next = l2cache_ctrl_pkg::fetch;
                    end
                end
            end

            l2cache_ctrl_pkg::write_back: begin
                // victim out first
                pmem_write = 1'b1;
                addr_src   = l2cache_ctrl_pkg::addr_wb;
                way_src    = l2cache_ctrl_pkg::way_lru;
                if (pmem_resp) begin
                    state_next = l2cache_ctrl_pkg::fetch;
                end
            end

            l2cache_ctrl_pkg::fetch: begin
                // refill into the lru way
                pmem_read = 1'b1;
                way_src   = l2cache_ctrl_pkg::way_lru;
                if (pmem_resp) begin
                    load_line     = 1'b1;
                    line_from_mem = 1'b1;
                    load_valid    = 1'b1;
                    valid_in      = 1'b1;
                    load_dirty    = 1'b1;
                    dirty_in      = 1'b0;
                    // retry, it hits now
                    state_next    = l2cache_ctrl_pkg::hit_check;
                end
            end

            default: begin
                state_next = l2cache_ctrl_pkg::idle;
            end
        endcase
    end

endmodule

//--- l2cache_datapath.sv
`timescale 1ns/1ps

module l2cache_datapath (
    input  logic                        clk,
    input  logic                        rst_n,
    // requester side
    input  l2cache_geom_pkg::l2_addr_t  mem_address,
    input  l2cache_geom_pkg::l2_line_t  mem_wdata,
    output l2cache_geom_pkg::l2_line_t  mem_rdata,
    // memory side
    output l2cache_geom_pkg::l2_addr_t  pmem_address,
    output l2cache_geom_pkg::l2_line_t  pmem_wdata,
    input  l2cache_geom_pkg::l2_line_t  pmem_rdata,
    // from control
    input  l2cache_ctrl_pkg::way_src_t  way_src,
    input  l2cache_ctrl_pkg::addr_src_t addr_src,
    input  logic                        load_line,
    input  logic                        load_valid,
    input  logic                        load_dirty,
    input  logic                        load_lru,
    input  logic                        load_wb_line,
    input  logic                        line_from_mem,
    input  logic                        valid_in,
    input  logic                        dirty_in,
    // to control
    output logic                        hit,
    output logic                        victim_dirty
);

    // address fields
    l2cache_geom_pkg::l2_tag_t   req_tag;
    l2cache_geom_pkg::l2_index_t idx;

    // array outputs per way
    l2cache_geom_pkg::l2_line_t  data_w0, data_w1;
    l2cache_geom_pkg::l2_tag_t   tag_w0, tag_w1;
    logic                        valid_w0, valid_w1;
    logic                        dirty_w0, dirty_w1;
    logic                        lru;

    // way selection and strobes
    logic                        hit_w0, hit_w1;
    logic                        way_sel;
    logic                        line_we_w0, line_we_w1;
    logic                        valid_we_w0, valid_we_w1;
    logic                        dirty_we_w0, dirty_we_w1;
    l2cache_geom_pkg::l2_line_t  line_in;

    // victim and write-back register
    l2cache_geom_pkg::l2_line_t  victim_line;
    l2cache_geom_pkg::l2_tag_t   victim_tag;
    l2cache_geom_pkg::l2_line_t  wb_line;
    l2cache_geom_pkg::l2_addr_t  wb_addr;

    assign req_tag = mem_address[l2cache_geom_pkg::addr_w-1 -: l2cache_geom_pkg::tag_bits];
    assign idx     = mem_address[l2cache_geom_pkg::offset_bits +: l2cache_geom_pkg::set_bits];

    // tag compare, a stale tag never counts
    assign hit_w0 = valid_w0 && (tag_w0 == req_tag);
    assign hit_w1 = valid_w1 && (tag_w1 == req_tag);
    assign hit    = hit_w0 || hit_w1;

    // 0 = way0, 1 = way1
    assign way_sel = (way_src == l2cache_ctrl_pkg::way_hit) ? hit_w1 : lru;

    // per-way strobes
    assign line_we_w0  = load_line  && !way_sel;
    assign line_we_w1  = load_line  &&  way_sel;
    assign valid_we_w0 = load_valid && !way_sel;
    assign valid_we_w1 = load_valid &&  way_sel;
    assign dirty_we_w0 = load_dirty && !way_sel;
    assign dirty_we_w1 = load_dirty &&  way_sel;

    // refill from memory or requester write
    assign line_in = line_from_mem ? pmem_rdata : mem_wdata;

    // line returned to requester
    assign mem_rdata = way_sel ? data_w1 : data_w0;

    // lru bit names the way to replace next
    assign victim_line  = lru ? data_w1 : data_w0;
    assign victim_tag   = lru ? tag_w1 : tag_w0;
    assign victim_dirty = lru ? (valid_w1 && dirty_w1) : (valid_w0 && dirty_w0);

    // data arrays
    l2cache_array #(.width(l2cache_geom_pkg::line_w), .rst_en(1'b0)) u_data_w0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .write   (line_we_w0),
        .index   (idx),
        .datain  (line_in),
        .dataout (data_w0)
    );
    l2cache_array #(.width(l2cache_geom_pkg::line_w), .rst_en(1'b0)) u_data_w1 (
        .clk     (clk),
        .rst_n   (rst_n),
        .write   (line_we_w1),
        .index   (idx),
        .datain  (line_in),
        .dataout (data_w1)
    );

    // tag arrays, written with the line
    l2cache_array #(.width(l2cache_geom_pkg::tag_bits), .rst_en(1'b0)) u_tag_w0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .write   (line_we_w0),
        .index   (idx),
        .datain  (req_tag),
        .dataout (tag_w0)
    );
    l2cache_array #(.width(l2cache_geom_pkg::tag_bits), .rst_en(1'b0)) u_tag_w1 (
        .clk     (clk),
        .rst_n   (rst_n),
        .write   (line_we_w1),
        .index   (idx),
        .datain  (req_tag),
        .dataout (tag_w1)
    );

    // valid bits
    l2cache_array #(.width(1), .rst_en(1'b1)) u_valid_w0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .write   (valid_we_w0),
        .index   (idx),
        .datain  (valid_in),
        .dataout (valid_w0)
    );
    l2cache_array #(.width(1), .rst_en(1'b1)) u_valid_w1 (
        .clk     (clk),
        .rst_n   (rst_n),
        .write   (valid_we_w1),
        .index   (idx),
        .datain  (valid_in),
        .dataout (valid_w1)
    );

    // dirty bits
    l2cache_array #(.width(1), .rst_en(1'b1)) u_dirty_w0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .write   (dirty_we_w0),
        .index   (idx),
        .datain  (dirty_in),
        .dataout (dirty_w0)
    );
    l2cache_array #(.width(1), .rst_en(1'b1)) u_dirty_w1 (
        .clk     (clk),
        .rst_n   (rst_n),
        .write   (dirty_we_w1),
        .index   (idx),
        .datain  (dirty_in),
        .dataout (dirty_w1)
    );

    // lru, points away from the way just used
    l2cache_array #(.width(1), .rst_en(1'b1)) u_lru (
        .clk     (clk),
        .rst_n   (rst_n),
        .write   (load_lru),
        .index   (idx),
        .datain  (!way_sel),
        .dataout (lru)
    );

    // victim capture, held through write_back
    always_ff @(posedge clk) begin
        if (load_wb_line) begin
            wb_line <= victim_line;
            wb_addr <= {victim_tag, idx, {l2cache_geom_pkg::offset_bits{1'b0}}};
        end
    end

    assign pmem_wdata = wb_line;

    // line-aligned request address or victim address
    assign pmem_address = (addr_src == l2cache_ctrl_pkg::addr_wb) ? wb_addr :
        {mem_address[l2cache_geom_pkg::addr_w-1:l2cache_geom_pkg::offset_bits],
         {l2cache_geom_pkg::offset_bits{1'b0}}};

endmodule

//--- l2cache_array.sv
`timescale 1ns/1ps

module l2cache_array #(
    parameter int width  = 1,
    parameter bit rst_en = 1'b0
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        write,
    input  l2cache_geom_pkg::l2_index_t index,
    input  logic [width-1:0]            datain,
    output logic [width-1:0]            dataout
);

    // one entry per set
    logic [width-1:0] mem [l2cache_geom_pkg::num_sets];

    // read straight from the index, no latency
    assign dataout = mem[index];

    generate
        if (rst_en) begin : g_rst
            // status bits start cleared
            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    for (int i = 0; i < l2cache_geom_pkg::num_sets; i++) begin
                        mem[i] <= '0;
                    end
                end else if (write) begin
                    mem[index] <= datain;
                end
            end
        end else begin : g_plain
            // line and tag storage
            always_ff @(posedge clk) begin
                if (write) begin
                    mem[index] <= datain;
                end
            end
        end
    endgenerate

endmodule

//--- l2cache_ctrl_pkg.sv
package l2cache_ctrl_pkg;

    // controller states
    typedef enum logic [1:0] {
        idle       = 2'd0,
        hit_check  = 2'd1,
        write_back = 2'd2,
        fetch      = 2'd3
    } l2_state_t;

    // which way the datapath acts on
    typedef enum logic {
        way_hit = 1'b0,
        way_lru = 1'b1
    } way_src_t;

    // source of the memory-side address
    typedef enum logic {
        addr_req = 1'b0,
        addr_wb  = 1'b1
    } addr_src_t;

endpackage

//--- l2cache_geom_pkg.sv
package l2cache_geom_pkg;

    // physical address width
    localparam int addr_w = 32;

    // one cache line, transferred whole in both directions
    localparam int line_w = 256;

    // byte offset inside a 32-byte line
    localparam int offset_bits = 5;

    // set index width
    localparam int set_bits = 4;

    // whatever is left of the address above index and offset
    localparam int tag_bits = addr_w - set_bits - offset_bits;

    // entries per storage array
    localparam int num_sets = 1 << set_bits;

    // vector types for the widths that carry a meaning
    typedef logic [addr_w-1:0]   l2_addr_t;
    typedef logic [line_w-1:0]   l2_line_t;
    typedef logic [tag_bits-1:0] l2_tag_t;
    typedef logic [set_bits-1:0] l2_index_t;

endpackage
